/* axi_bridge.f */
src/axi_bridge_pkg.sv
src/axi_burst_iter.sv
src/axi_axil_reflect_wr.sv
src/axi_axil_adapter_wr.sv
src/axil_reg_mem.sv
src/axi_bridge_top.sv
bench/axi_bridge_properties.sv
bench/axi_bridge_tb.sv

/* bench/axi_bridge_properties.sv */
module axi_bridge_properties
  import axi_bridge_pkg::*;
#(
  parameter int ADDR_W = axi_bridge_pkg::ADDR_W,
  parameter int DATA_W = axi_bridge_pkg::DATA_W
) (
  input logic              clk,
  input logic              i_rst,
  input axi_aw_t           i_aw,
  input logic              i_awvalid,
  input logic              o_awready,
  input axi_w_t            i_w,
  input logic              i_wvalid,
  input logic              o_wready,
  input axi_b_t            o_b,
  input logic              o_bvalid,
  input logic              i_bready,
  input logic [ADDR_W-1:0] o_axil_awaddr,
  input logic              o_axil_awvalid,
  input logic              i_axil_awready,
  input logic [DATA_W-1:0] o_axil_wdata,
  input logic              o_axil_wvalid,
  input logic              i_axil_wready
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [7:0] aw_count;
  logic [7:0] b_count;
  int         fail_count = 0;

  // Accepted bursts against returned responses
  always_ff @(posedge clk) begin
    if (i_rst) begin
      aw_count <= '0;
      b_count  <= '0;
    end else begin
      if (i_awvalid && o_awready) begin
        aw_count <= aw_count + 8'd1;
      end
      if (o_bvalid && i_bready) begin
        b_count <= b_count + 8'd1;
      end
    end
  end

  aw_hold: assert property (@(posedge clk) disable iff (i_rst)
    i_awvalid && !o_awready |=> i_awvalid && $stable(i_aw))
    else begin
      fail_count++;
      $error("AW valid dropped or payload changed before acceptance");
    end

  w_hold: assert property (@(posedge clk) disable iff (i_rst)
    i_wvalid && !o_wready |=> i_wvalid && $stable(i_w))
    else begin
      fail_count++;
      $error("W valid dropped or payload changed before acceptance");
    end

  b_hold: assert property (@(posedge clk) disable iff (i_rst)
    o_bvalid && !i_bready |=> o_bvalid && $stable(o_b))
    else begin
      fail_count++;
      $error("B valid dropped or payload changed before acceptance");
    end

  axil_aw_hold: assert property (@(posedge clk) disable iff (i_rst)
    o_axil_awvalid && !i_axil_awready |=> o_axil_awvalid && $stable(o_axil_awaddr))
    else begin
      fail_count++;
      $error("AXI-Lite AW not held until accepted");
    end

  axil_w_hold: assert property (@(posedge clk) disable iff (i_rst)
    o_axil_wvalid && !i_axil_wready |=> o_axil_wvalid && $stable(o_axil_wdata))
    else begin
      fail_count++;
      $error("AXI-Lite W not held until accepted");
    end

  b_low_in_reset: assert property (@(posedge clk) i_rst |=> !o_bvalid)
    else begin
      fail_count++;
      $error("B valid high during reset");
    end

  b_count_bound: assert property (@(posedge clk) disable iff (i_rst)
    b_count <= aw_count)
    else begin
      fail_count++;
      $error("More B responses than accepted AW bursts");
    end

endmodule

bind axi_axil_adapter_wr axi_bridge_properties #(
  .ADDR_W(ADDR_W),
  .DATA_W(DATA_W)
) i_props (.*);

/* bench/axi_bridge_tb.sv */
module axi_bridge_tb
  import axi_bridge_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MEM_WORDS = 16;
  localparam int NUM_ROWS  = 9;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
    axi_burst_e        burst;
    logic [2:0]        size;
    logic [31:0]       seed;
    logic [3:0]        strb;
    logic [7:0]        stall;
  } test_row_t;

  logic              clk = 1'b0;
  logic              i_rst;
  axi_aw_t           i_aw;
  logic              i_awvalid;
  logic              o_awready;
  axi_w_t            i_w;
  logic              i_wvalid;
  logic              o_wready;
  axi_b_t            o_b;
  logic              o_bvalid;
  logic              i_bready;
  logic [ADDR_W-1:0] i_rd_addr;
  logic [DATA_W-1:0] o_rd_data;

  test_row_t   rows [NUM_ROWS];
  logic [31:0] model_mem [MEM_WORDS];
  integer      seed;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          limit = 0;

  axi_bridge_top #(
    .OUTSTANDING_W(1),
    .MEM_WORDS    (MEM_WORDS)
  ) i_dut (
    .clk      (clk),
    .i_rst    (i_rst),
    .i_aw     (i_aw),
    .i_awvalid(i_awvalid),
    .o_awready(o_awready),
    .i_w      (i_w),
    .i_wvalid (i_wvalid),
    .o_wready (o_wready),
    .o_b      (o_b),
    .o_bvalid (o_bvalid),
    .i_bready (i_bready),
    .i_rd_addr(i_rd_addr),
    .o_rd_data(o_rd_data)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("Done: errors found");
      $finish;
    end
  end

  task automatic check_eq(input logic [31:0] exp_val, input logic [31:0] act_val,
                          input string what);
    checks++;
    if (act_val !== exp_val) begin
      errors++;
      $display("ERR %0t: %s, expected %h, got %h", $time, what, exp_val, act_val);
    end
  endtask

  // Strobe pattern rotates left by one byte per beat
  function automatic logic [3:0] strobe_for_beat(input logic [3:0] pattern, input int k);
    logic [7:0] dbl;
    dbl = {pattern, pattern};
    return dbl[7 - (k % 4) -: 4];
  endfunction

  task automatic load_table();
    // id, addr, len, burst, size, seed, strb, stall
    rows[0] = '{4'h1, 8'h00, 8'd0, BURST_INCR,  3'd2, 32'h0000_0000, 4'hf, 8'd0};
    rows[1] = '{4'h2, 8'h04, 8'd0, BURST_INCR,  3'd2, 32'h1111_0000, 4'hf, 8'd0};
    rows[2] = '{4'h3, 8'h10, 8'd3, BURST_INCR,  3'd2, 32'h0000_2222, 4'hf, 8'd0};
    rows[3] = '{4'h4, 8'h14, 8'd1, BURST_INCR,  3'd2, 32'h3300_3300, 4'h5, 8'd0};
    rows[4] = '{4'h5, 8'h20, 8'd2, BURST_FIXED, 3'd2, 32'h0044_0044, 4'h3, 8'd0};
    // Last two beats fall past the memory end
    rows[5] = '{4'h6, 8'h38, 8'd3, BURST_INCR,  3'd2, 32'h5555_5555, 4'hf, 8'd0};
    rows[6] = '{4'h7, 8'h08, 8'd1, BURST_INCR,  3'd2, 32'h6600_0066, 4'hf, 8'd5};
    rows[7] = '{4'h8, 8'h0c, 8'd0, BURST_INCR,  3'd2, 32'h0077_7700, 4'hf, 8'd3};
    rows[8] = '{4'h9, 8'h28, 8'd0, BURST_INCR,  3'd2, 32'h8888_0000, 4'he, 8'd0};
  endtask

  // Drives AW then the W beats and updates the model memory
  task automatic send_burst(input test_row_t row, output axi_resp_e exp_resp);
    axi_aw_t           aw;
    axi_w_t            w;
    logic [ADDR_W-1:0] baddr;
    aw.addr  = row.addr;
    aw.id    = row.id;
    aw.len   = row.len;
    aw.size  = row.size;
    aw.burst = row.burst;
    exp_resp = RESP_OKAY;
    @(posedge clk);
    #1;
    i_aw      = aw;
    i_awvalid = 1'b1;
    @(negedge clk);
    while (!o_awready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    i_awvalid = 1'b0;
    for (int k = 0; k <= int'(row.len); k++) begin
      w.data   = $random(seed) ^ row.seed;
      w.strb   = strobe_for_beat(row.strb, k);
      w.last   = (k == int'(row.len));
      i_w      = w;
      i_wvalid = 1'b1;
      baddr = row.addr;
      if (row.burst != BURST_FIXED) begin
        baddr = row.addr + ADDR_W'(k << row.size);
      end
      if (int'(baddr) < MEM_WORDS * 4) begin
        for (int b = 0; b < 4; b++) begin
          if (w.strb[b]) begin
            model_mem[baddr >> 2][8*b +: 8] = w.data[8*b +: 8];
          end
        end
      end else begin
        exp_resp = RESP_SLVERR;
      end
      @(negedge clk);
      while (!o_wready) begin
        @(negedge clk);
      end
      @(posedge clk);
      #1;
    end
    i_wvalid = 1'b0;
  endtask

  task automatic collect_b(input test_row_t row, input axi_resp_e exp_resp);
    axi_b_t first;
    @(negedge clk);
    while (!o_bvalid) begin
      @(negedge clk);
    end
    first = o_b;
    check_eq(32'(row.id), 32'(first.id), "B id");
    check_eq(32'(exp_resp), 32'(first.resp), "B resp");
    for (int k = 0; k < int'(row.stall); k++) begin
      @(negedge clk);
      check_eq(32'(1), 32'(o_bvalid), "B valid held while stalled");
      check_eq(32'(first), 32'(o_b), "B payload held while stalled");
    end
    @(posedge clk);
    #1;
    i_bready = 1'b1;
    @(posedge clk);
    #1;
    i_bready = 1'b0;
    @(negedge clk);
    check_eq(32'(0), 32'(o_bvalid), "one B per burst");
  endtask

  task automatic read_back();
    for (int w = 0; w < MEM_WORDS; w++) begin
      @(posedge clk);
      #1;
      i_rd_addr = ADDR_W'(w * 4);
      @(negedge clk);
      check_eq(model_mem[w], o_rd_data, $sformatf("readback word %0d", w));
    end
  endtask

  initial begin
    axi_resp_e exp_resp [NUM_ROWS];
    int        errs_before;
    seed      = 32'he01c;
    i_rst     = 1'b1;
    i_aw      = '0;
    i_awvalid = 1'b0;
    i_w       = '0;
    i_wvalid  = 1'b0;
    i_bready  = 1'b0;
    i_rd_addr = '0;
    load_table();
    for (int t = 0; t < NUM_ROWS; t++) begin
      limit += (int'(rows[t].len) + 1 + int'(rows[t].stall) + 10) * 4;
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      model_mem[i] = '0;
    end
    repeat (4) @(posedge clk);
    #1;
    i_rst = 1'b0;
    for (int t = 0; t < NUM_ROWS; t++) begin
      errs_before = errors;
      // A row behind a stalled row is already in flight
      if (t == 0 || rows[t-1].stall == 0) begin
        send_burst(rows[t], exp_resp[t]);
      end
      // Next burst queues up behind the stalled B, so B order is visible
      if (rows[t].stall != 0 && t + 1 < NUM_ROWS) begin
        send_burst(rows[t+1], exp_resp[t+1]);
      end
      collect_b(rows[t], exp_resp[t]);
      read_back();
      $display("Test %0d id %0h len %0d: %s", t, rows[t].id, rows[t].len,
               (errors == errs_before) ? "ok" : "FAILED");
    end
    errors += i_dut.i_adapter.i_props.fail_count;
    $display("Tests %0d, checks %0d, errors %0d", NUM_ROWS, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f axi_bridge.f \
  --top-module axi_bridge_tb -Mdir obj_dir -o sim \
  && ./obj_dir/sim | tee sim.log \
  || { echo "Build or simulation failed"; exit 1; }
grep -qx "Done: no errors" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

/* src/axi_axil_adapter_wr.sv */
module axi_axil_adapter_wr
  import axi_bridge_pkg::*;
#(
  parameter int ADDR_W        = axi_bridge_pkg::ADDR_W,
  parameter int DATA_W        = axi_bridge_pkg::DATA_W,
  parameter int ID_W          = axi_bridge_pkg::ID_W,
  parameter int OUTSTANDING_W = 1
) (
  input  logic                clk,
  input  logic                i_rst,
  // AXI subordinate
  input  axi_aw_t             i_aw,
  input  logic                i_awvalid,
  output logic                o_awready,
  input  axi_w_t              i_w,
  input  logic                i_wvalid,
  output logic                o_wready,
  output axi_b_t              o_b,
  output logic                o_bvalid,
  input  logic                i_bready,
  // AXI-Lite manager
  output logic [ADDR_W-1:0]   o_axil_awaddr,
  output logic                o_axil_awvalid,
  input  logic                i_axil_awready,
  output logic [DATA_W-1:0]   o_axil_wdata,
  output logic [DATA_W/8-1:0] o_axil_wstrb,
  output logic                o_axil_wvalid,
  input  logic                i_axil_wready,
  input  axi_resp_e           i_axil_bresp,
  input  logic                i_axil_bvalid,
  output logic                o_axil_bready
);

  // Split beat stream between the two stages
  beat_aw_t split_beat;
  logic     split_valid;
  logic     split_ready;

  axi_burst_iter #(
    .ADDR_W(ADDR_W)
  ) i_iter (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_aw        (i_aw),
    .i_awvalid   (i_awvalid),
    .o_awready   (o_awready),
    .o_beat      (split_beat),
    .o_beat_valid(split_valid),
    .i_beat_ready(split_ready)
  );

  axi_axil_reflect_wr #(
    .ADDR_W       (ADDR_W),
    .DATA_W       (DATA_W),
    .ID_W         (ID_W),
    .OUTSTANDING_W(OUTSTANDING_W)
  ) i_reflect (
    .clk           (clk),
    .i_rst         (i_rst),
    .i_beat        (split_beat),
    .i_beat_valid  (split_valid),
    .o_beat_ready  (split_ready),
    .i_w           (i_w),
    .i_wvalid      (i_wvalid),
    .o_wready      (o_wready),
    .o_b           (o_b),
    .o_bvalid      (o_bvalid),
    .i_bready      (i_bready),
    .o_axil_awaddr (o_axil_awaddr),
    .o_axil_awvalid(o_axil_awvalid),
    .i_axil_awready(i_axil_awready),
    .o_axil_wdata  (o_axil_wdata),
    .o_axil_wstrb  (o_axil_wstrb),
    .o_axil_wvalid (o_axil_wvalid),
    .i_axil_wready (i_axil_wready),
    .i_axil_bresp  (i_axil_bresp),
    .i_axil_bvalid (i_axil_bvalid),
    .o_axil_bready (o_axil_bready)
  );

endmodule

/* src/axi_axil_reflect_wr.sv */
module axi_axil_reflect_wr
  import axi_bridge_pkg::*;
#(
  parameter int ADDR_W        = axi_bridge_pkg::ADDR_W,
  parameter int DATA_W        = axi_bridge_pkg::DATA_W,
  parameter int ID_W          = axi_bridge_pkg::ID_W,
  parameter int OUTSTANDING_W = 1
) (
  input  logic                clk,
  input  logic                i_rst,
  input  beat_aw_t            i_beat,
  input  logic                i_beat_valid,
  output logic                o_beat_ready,
  input  axi_w_t              i_w,
  input  logic                i_wvalid,
  output logic                o_wready,
  output axi_b_t              o_b,
  output logic                o_bvalid,
  input  logic                i_bready,
  output logic [ADDR_W-1:0]   o_axil_awaddr,
  output logic                o_axil_awvalid,
  input  logic                i_axil_awready,
  output logic [DATA_W-1:0]   o_axil_wdata,
  output logic [DATA_W/8-1:0] o_axil_wstrb,
  output logic                o_axil_wvalid,
  input  logic                i_axil_wready,
  input  axi_resp_e           i_axil_bresp,
  input  logic                i_axil_bvalid,
  output logic                o_axil_bready
);

  localparam int DEPTH = 1 << OUTSTANDING_W;

  logic [ID_W-1:0]        q_id [DEPTH];
  logic                   q_last [DEPTH];
  logic [OUTSTANDING_W:0] wr_ptr_q;
  logic [OUTSTANDING_W:0] rd_ptr_q;
  logic                   q_full;
  logic                   req_free;
  logic                   accept;
  logic                   pop;
  axi_resp_e              resp_acc_q;
  axi_resp_e              folded;
  axi_b_t                 b_q;
  logic                   bvalid_q;

  // Full when the pointers differ only in the wrap bit
  assign q_full = (wr_ptr_q[OUTSTANDING_W] != rd_ptr_q[OUTSTANDING_W]) &&
                  (wr_ptr_q[OUTSTANDING_W-1:0] == rd_ptr_q[OUTSTANDING_W-1:0]);

  // Request registers free now or emptying this cycle
  assign req_free = (!o_axil_awvalid || i_axil_awready) &&
                    (!o_axil_wvalid || i_axil_wready);

  // Address beat and data beat are taken together
  assign accept       = i_beat_valid && i_wvalid && !q_full && req_free;
  assign o_beat_ready = i_wvalid && !q_full && req_free;
  assign o_wready     = i_beat_valid && !q_full && req_free;

  // Hold off responses while AXI B is stalled
  assign o_axil_bready = !bvalid_q;
  assign pop           = i_axil_bvalid && o_axil_bready;
  assign folded        = (i_axil_bresp > resp_acc_q) ? i_axil_bresp : resp_acc_q;

  assign o_b      = b_q;
  assign o_bvalid = bvalid_q;

  // AXI-Lite request, AW and W retire independently
  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_axil_awvalid <= 1'b0;
      o_axil_wvalid  <= 1'b0;
    end else if (accept) begin
      o_axil_awvalid <= 1'b1;
      o_axil_wvalid  <= 1'b1;
    end else begin
      if (i_axil_awready) begin
        o_axil_awvalid <= 1'b0;
      end
      if (i_axil_wready) begin
        o_axil_wvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      o_axil_awaddr <= i_beat.addr;
      o_axil_wdata  <= i_w.data;
      o_axil_wstrb  <= i_w.strb;
      q_id[wr_ptr_q[OUTSTANDING_W-1:0]]   <= i_beat.id;
      q_last[wr_ptr_q[OUTSTANDING_W-1:0]] <= i_beat.last;
    end
  end

  // Queue pointers, response fold and AXI B
  always_ff @(posedge clk) begin
    if (i_rst) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      resp_acc_q <= RESP_OKAY;
      bvalid_q   <= 1'b0;
    end else begin
      if (accept) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (bvalid_q && i_bready) begin
        bvalid_q <= 1'b0;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
        if (q_last[rd_ptr_q[OUTSTANDING_W-1:0]]) begin
          bvalid_q   <= 1'b1;
          resp_acc_q <= RESP_OKAY;
        end else begin
          resp_acc_q <= folded;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop && q_last[rd_ptr_q[OUTSTANDING_W-1:0]]) begin
      b_q.id   <= q_id[rd_ptr_q[OUTSTANDING_W-1:0]];
      b_q.resp <= folded;
    end
  end

endmodule

/* src/axi_bridge_pkg.sv */
package axi_bridge_pkg;

  // Default widths, module parameters start from these
  parameter int ADDR_W = 8;
  parameter int DATA_W = 32;
  parameter int ID_W   = 4;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'd0,
    BURST_INCR  = 2'd1,
    BURST_WRAP  = 2'd2
  } axi_burst_e;

  // Ordered so that a higher code is the worse response
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_EXOKAY = 2'd1,
    RESP_SLVERR = 2'd2,
    RESP_DECERR = 2'd3
  } axi_resp_e;

  // AXI write address channel payload
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [ID_W-1:0]   id;
    logic [7:0]        len;
    logic [2:0]        size;
    axi_burst_e        burst;
  } axi_aw_t;

  // AXI write data channel payload
  typedef struct packed {
    logic [DATA_W-1:0]   data;
    logic [DATA_W/8-1:0] strb;
    logic                last;
  } axi_w_t;

  // AXI write response payload
  typedef struct packed {
    logic [ID_W-1:0] id;
    axi_resp_e       resp;
  } axi_b_t;

  // One beat of a split burst
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [ID_W-1:0]   id;
    logic              last;
  } beat_aw_t;

endpackage

/* src/axi_bridge_top.sv */
module axi_bridge_top
  import axi_bridge_pkg::*;
#(
  parameter int ADDR_W        = axi_bridge_pkg::ADDR_W,
  parameter int DATA_W        = axi_bridge_pkg::DATA_W,
  parameter int ID_W          = axi_bridge_pkg::ID_W,
  parameter int OUTSTANDING_W = 1,
  parameter int MEM_WORDS     = 16
) (
  input  logic              clk,
  input  logic              i_rst,
  input  axi_aw_t           i_aw,
  input  logic              i_awvalid,
  output logic              o_awready,
  input  axi_w_t            i_w,
  input  logic              i_wvalid,
  output logic              o_wready,
  output axi_b_t            o_b,
  output logic              o_bvalid,
  input  logic              i_bready,
  input  logic [ADDR_W-1:0] i_rd_addr,
  output logic [DATA_W-1:0] o_rd_data
);

  // AXI-Lite link between bridge and memory
  logic [ADDR_W-1:0]   axil_awaddr;
  logic                axil_awvalid;
  logic                axil_awready;
  logic [DATA_W-1:0]   axil_wdata;
  logic [DATA_W/8-1:0] axil_wstrb;
  logic                axil_wvalid;
  logic                axil_wready;
  axi_resp_e           axil_bresp;
  logic                axil_bvalid;
  logic                axil_bready;

  axi_axil_adapter_wr #(
    .ADDR_W       (ADDR_W),
    .DATA_W       (DATA_W),
    .ID_W         (ID_W),
    .OUTSTANDING_W(OUTSTANDING_W)
  ) i_adapter (
    .clk           (clk),
    .i_rst         (i_rst),
    .i_aw          (i_aw),
    .i_awvalid     (i_awvalid),
    .o_awready     (o_awready),
    .i_w           (i_w),
    .i_wvalid      (i_wvalid),
    .o_wready      (o_wready),
    .o_b           (o_b),
    .o_bvalid      (o_bvalid),
    .i_bready      (i_bready),
    .o_axil_awaddr (axil_awaddr),
    .o_axil_awvalid(axil_awvalid),
    .i_axil_awready(axil_awready),
    .o_axil_wdata  (axil_wdata),
    .o_axil_wstrb  (axil_wstrb),
    .o_axil_wvalid (axil_wvalid),
    .i_axil_wready (axil_wready),
    .i_axil_bresp  (axil_bresp),
    .i_axil_bvalid (axil_bvalid),
    .o_axil_bready (axil_bready)
  );

  axil_reg_mem #(
    .ADDR_W   (ADDR_W),
    .DATA_W   (DATA_W),
    .MEM_WORDS(MEM_WORDS)
  ) i_mem (
    .clk      (clk),
    .i_rst    (i_rst),
    .i_awaddr (axil_awaddr),
    .i_awvalid(axil_awvalid),
    .o_awready(axil_awready),
    .i_wdata  (axil_wdata),
    .i_wstrb  (axil_wstrb),
    .i_wvalid (axil_wvalid),
    .o_wready (axil_wready),
    .o_bresp  (axil_bresp),
    .o_bvalid (axil_bvalid),
    .i_bready (axil_bready),
    .i_rd_addr(i_rd_addr),
    .o_rd_data(o_rd_data)
  );

endmodule

/* src/axi_burst_iter.sv */
module axi_burst_iter
  import axi_bridge_pkg::*;
#(
  parameter int ADDR_W = axi_bridge_pkg::ADDR_W
) (
  input  logic     clk,
  input  logic     i_rst,
  input  axi_aw_t  i_aw,
  input  logic     i_awvalid,
  output logic     o_awready,
  output beat_aw_t o_beat,
  output logic     o_beat_valid,
  input  logic     i_beat_ready
);

  typedef enum logic {
    ITER_IDLE,
    ITER_BURST
  } iter_state_e;

  iter_state_e       state_q;
  logic [ADDR_W-1:0] addr_q;
  logic [ADDR_W-1:0] step_q;
  logic [ID_W-1:0]   id_q;
  logic [7:0]        count_q;
  logic              beat_last;
  logic              aw_fire;
  logic              beat_fire;

  // Only one burst in progress at a time
  assign o_awready = (state_q == ITER_IDLE);
  assign aw_fire   = i_awvalid && o_awready;

  // Count runs down to zero on the final beat
  assign beat_last = (count_q == 8'd0);
  assign beat_fire = o_beat_valid && i_beat_ready;

  assign o_beat_valid = (state_q == ITER_BURST);
  assign o_beat.addr  = addr_q;
  assign o_beat.id    = id_q;
  assign o_beat.last  = beat_last;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      state_q <= ITER_IDLE;
    end else begin
      case (state_q)
        ITER_IDLE: begin
          if (aw_fire) begin
            state_q <= ITER_BURST;
          end
        end
        ITER_BURST: begin
          if (beat_fire && beat_last) begin
            state_q <= ITER_IDLE;
          end
        end
        default: state_q <= ITER_IDLE;
      endcase
    end
  end

  // Burst payload registers
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      addr_q  <= i_aw.addr;
      id_q    <= i_aw.id;
      count_q <= i_aw.len;
      // WRAP is not supported and steps like INCR
      if (i_aw.burst == BURST_FIXED) begin
        step_q <= '0;
      end else begin
        step_q <= ADDR_W'(1) << i_aw.size;
      end
    end else if (beat_fire && !beat_last) begin
      addr_q  <= addr_q + step_q;
      count_q <= count_q - 8'd1;
    end
  end

endmodule

/* src/axil_reg_mem.sv */
module axil_reg_mem
  import axi_bridge_pkg::*;
#(
  parameter int ADDR_W    = axi_bridge_pkg::ADDR_W,
  parameter int DATA_W    = axi_bridge_pkg::DATA_W,
  parameter int MEM_WORDS = 16
) (
  input  logic                clk,
  input  logic                i_rst,
  input  logic [ADDR_W-1:0]   i_awaddr,
  input  logic                i_awvalid,
  output logic                o_awready,
  input  logic [DATA_W-1:0]   i_wdata,
  input  logic [DATA_W/8-1:0] i_wstrb,
  input  logic                i_wvalid,
  output logic                o_wready,
  output axi_resp_e           o_bresp,
  output logic                o_bvalid,
  input  logic                i_bready,
  input  logic [ADDR_W-1:0]   i_rd_addr,
  output logic [DATA_W-1:0]   o_rd_data
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  logic [DATA_W-1:0] mem [MEM_WORDS];
  logic              wr_fire;
  logic              wr_in_range;
  logic              rd_in_range;
  logic [IDX_W-1:0]  wr_idx;
  logic [IDX_W-1:0]  rd_idx;

  // AW and W only move together, one write per response
  assign o_awready = i_wvalid && !o_bvalid;
  assign o_wready  = i_awvalid && !o_bvalid;
  assign wr_fire   = i_awvalid && i_wvalid && !o_bvalid;

  // Word index is the byte address divided by 4
  assign wr_idx      = i_awaddr[IDX_W+1:2];
  assign rd_idx      = i_rd_addr[IDX_W+1:2];
  assign wr_in_range = int'(i_awaddr) < MEM_WORDS * 4;
  assign rd_in_range = int'(i_rd_addr) < MEM_WORDS * 4;

  assign o_rd_data = rd_in_range ? mem[rd_idx] : '0;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_bvalid <= 1'b0;
      o_bresp  <= RESP_OKAY;
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else begin
      if (o_bvalid && i_bready) begin
        o_bvalid <= 1'b0;
      end
      if (wr_fire) begin
        o_bvalid <= 1'b1;
        o_bresp  <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
        // Out of range writes are dropped
        if (wr_in_range) begin
          for (int b = 0; b < DATA_W / 8; b++) begin
            if (i_wstrb[b]) begin
              mem[wr_idx][8*b +: 8] <= i_wdata[8*b +: 8];
            end
          end
        end
      end
    end
  end

endmodule
